/* src/cache_pkg.sv */
// Cache widths, word and line types, processor and memory request structs
package cache_pkg;

    // ----------------------------------------
    // Widths
    // ----------------------------------------
    localparam int WORD_BITS      = 32;
    localparam int WORDS_PER_LINE = 4;
    localparam int LINE_BITS      = WORD_BITS * WORDS_PER_LINE;
    localparam int OFFSET_BITS    = $clog2(WORDS_PER_LINE);  // Word offset inside a line
    localparam int WORD_ADDR_BITS = 30;                      // Byte address [31:2]
    localparam int LINE_ADDR_BITS = WORD_ADDR_BITS - OFFSET_BITS;

    // ----------------------------------------
    // Data and address types
    // ----------------------------------------
    typedef logic [WORD_BITS-1:0]      word_t;
    typedef logic [WORD_ADDR_BITS-1:0] word_addr_t;
    typedef logic [LINE_BITS-1:0]      line_t;       // Word 0 in the low bits
    typedef logic [LINE_ADDR_BITS-1:0] line_addr_t;

    // ----------------------------------------
    // Request and response structs
    // ----------------------------------------

    // Processor side of the data cache
    typedef struct packed {
        logic       read;
        logic       write;
        word_addr_t addr;
        word_t      wdata;
    } proc_req_t;

    // Line-wide request towards slow memory
    typedef struct packed {
        logic       read;
        logic       write;
        line_addr_t addr;
        line_t      wdata;
    } mem_req_t;

    typedef struct packed {
        logic  ready;  // One-cycle pulse
        line_t rdata;  // Valid with ready on a read
    } mem_rsp_t;

endpackage

/* src/cache_line_store.sv */
// Direct-mapped line store with valid bits, tags, line data, hit check and word select
`timescale 1ns/1ns

module cache_line_store #(
    parameter int NUM_LINES = 8
) (
    input  logic                  clk,
    input  logic                  rst_n,
    input  cache_pkg::word_addr_t addr,
    input  logic                  line_we,
    input  cache_pkg::line_t      line_in,
    output logic                  hit,
    output cache_pkg::word_t      rdata,
    output cache_pkg::line_t      line_out,
    output cache_pkg::line_addr_t victim_addr
);
    import cache_pkg::*;

    localparam int INDEX_BITS = $clog2(NUM_LINES);
    localparam int TAG_BITS   = LINE_ADDR_BITS - INDEX_BITS;

    typedef logic [TAG_BITS-1:0]   tag_t;
    typedef logic [INDEX_BITS-1:0] index_t;

    // ----------------------------------------
    // Storage
    // ----------------------------------------
    logic [NUM_LINES-1:0] valid;
    tag_t                 tags  [NUM_LINES];
    line_t                lines [NUM_LINES];

    // Address fields
    tag_t                   addr_tag;
    index_t                 index;
    logic [OFFSET_BITS-1:0] offset;

    assign addr_tag = addr[WORD_ADDR_BITS-1 -: TAG_BITS];
    assign index    = addr[OFFSET_BITS +: INDEX_BITS];
    assign offset   = addr[OFFSET_BITS-1:0];

    // ----------------------------------------
    // Lookup
    // ----------------------------------------
    assign line_out    = lines[index];
    assign hit         = valid[index] & (tags[index] == addr_tag);
    assign rdata       = line_out[offset*WORD_BITS +: WORD_BITS];  // Addressed word
    assign victim_addr = {tags[index], index};                     // Line currently held

    // Valid bits clear after reset
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            valid <= '0;
        end else if (line_we) begin
            valid[index] <= 1'b1;
        end
    end

    // Tag and data arrays
    always_ff @(posedge clk) begin
        if (line_we) begin
            tags[index]  <= addr_tag;
            lines[index] <= line_in;
        end
    end

endmodule

/* src/icache.sv */
// Read-only instruction cache with a single-miss refill controller
`timescale 1ns/1ns

module icache #(
    parameter int NUM_LINES = 8
) (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  fetch_read,
    input  cache_pkg::word_addr_t fetch_addr,
    output cache_pkg::word_t      fetch_rdata,
    output logic                  fetch_stall,
    output logic                  mem_read,
    output cache_pkg::line_addr_t mem_addr,
    input  cache_pkg::mem_rsp_t   mem_rsp
);
    import cache_pkg::*;

    typedef enum logic {
        IDLE,
        REFILL
    } state_t;

    state_t state;
    state_t state_nxt;
    logic   hit;
    logic   line_we;

    // ----------------------------------------
    // Line store
    // ----------------------------------------
    cache_line_store #(
        .NUM_LINES (NUM_LINES)
    ) u_store (
        .clk         (clk),
        .rst_n       (rst_n),
        .addr        (fetch_addr),
        .line_we     (line_we),
        .line_in     (mem_rsp.rdata),
        .hit         (hit),
        .rdata       (fetch_rdata),
        .line_out    (),
        .victim_addr ()
    );

    assign fetch_stall = fetch_read & ~hit;
    assign line_we     = (state == REFILL) & mem_rsp.ready;  // Fill on the ready pulse

    // ----------------------------------------
    // Refill FSM
    // ----------------------------------------
    always_comb begin
        state_nxt = state;
        case (state)
            IDLE:    if (fetch_stall) state_nxt = REFILL;
            REFILL:  if (mem_rsp.ready) state_nxt = IDLE;
            default: state_nxt = IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state    <= IDLE;
            mem_read <= 1'b0;
        end else begin
            state <= state_nxt;
            if (state == IDLE && fetch_stall) begin
                mem_read <= 1'b1;
            end else if (line_we) begin
                mem_read <= 1'b0;  // Held until ready
            end
        end
    end

    // Line address of the missing fetch
    always_ff @(posedge clk) begin
        if (state == IDLE && fetch_stall) begin
            mem_addr <= fetch_addr[WORD_ADDR_BITS-1:OFFSET_BITS];
        end
    end

endmodule

/* src/dcache.sv */
// Write-back, write-allocate data cache with dirty bits and a single-miss FSM
`timescale 1ns/1ns

module dcache #(
    parameter int NUM_LINES = 8
) (
    input  logic                 clk,
    input  logic                 rst_n,
    input  cache_pkg::proc_req_t req,
    output cache_pkg::word_t     rdata,
    output logic                 stall,
    output cache_pkg::mem_req_t  mem_req,
    input  cache_pkg::mem_rsp_t  mem_rsp
);
    import cache_pkg::*;

    localparam int INDEX_BITS = $clog2(NUM_LINES);

    typedef enum logic [1:0] {
        IDLE,
        WRITE_BACK,
        ALLOCATE
    } state_t;

    state_t state;
    state_t state_nxt;

    logic [NUM_LINES-1:0]   dirty;
    logic                   pend_write;    // Last access was a write
    logic [INDEX_BITS-1:0]  index;
    logic [OFFSET_BITS-1:0] offset;
    line_addr_t             req_line;

    // Line store side
    logic       hit;
    logic       line_we;
    logic       write_hit;
    logic       refill;
    line_t      line_out;
    line_t      line_in;
    line_t      merged;
    line_addr_t victim_addr;

    // Registered memory request
    logic       mem_read_q;
    logic       mem_write_q;
    line_addr_t mem_addr_q;
    line_t      mem_wdata_q;

    assign index    = req.addr[OFFSET_BITS +: INDEX_BITS];
    assign offset   = req.addr[OFFSET_BITS-1:0];
    assign req_line = req.addr[WORD_ADDR_BITS-1:OFFSET_BITS];

    // ----------------------------------------
    // Line store and write merge
    // ----------------------------------------
    cache_line_store #(
        .NUM_LINES (NUM_LINES)
    ) u_store (
        .clk         (clk),
        .rst_n       (rst_n),
        .addr        (req.addr),
        .line_we     (line_we),
        .line_in     (line_in),
        .hit         (hit),
        .rdata       (rdata),
        .line_out    (line_out),
        .victim_addr (victim_addr)
    );

    always_comb begin
        merged = line_out;
        merged[offset*WORD_BITS +: WORD_BITS] = req.wdata;  // Store word into held line
    end

    assign stall     = (req.read | req.write) & ~hit;
    assign write_hit = (state == IDLE) & req.write & hit;
    assign refill    = (state == ALLOCATE) & mem_rsp.ready;
    assign line_we   = write_hit | refill;
    assign line_in   = refill ? mem_rsp.rdata : merged;

    // ----------------------------------------
    // Miss FSM
    // ----------------------------------------
    always_comb begin
        state_nxt = state;
        case (state)
            IDLE: begin
                if (stall) begin
                    state_nxt = dirty[index] ? WRITE_BACK : ALLOCATE;
                end
            end
            WRITE_BACK: if (mem_rsp.ready) state_nxt = ALLOCATE;
            ALLOCATE:   if (mem_rsp.ready) state_nxt = IDLE;
            default:    state_nxt = IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state       <= IDLE;
            mem_read_q  <= 1'b0;
            mem_write_q <= 1'b0;
            dirty       <= '0;
            pend_write  <= 1'b0;
        end else begin
            state <= state_nxt;
            if (req.write) begin
                pend_write <= 1'b1;
            end else if (req.read) begin
                pend_write <= 1'b0;
            end
            if (state == IDLE && stall) begin
                mem_write_q <= dirty[index];   // Victim goes out first
                mem_read_q  <= ~dirty[index];
            end else if (state == WRITE_BACK && mem_rsp.ready) begin
                mem_write_q <= 1'b0;
                mem_read_q  <= 1'b1;
            end else if (refill) begin
                mem_read_q  <= 1'b0;
            end
            if (write_hit) begin
                dirty[index] <= 1'b1;
            end else if (refill) begin
                dirty[index] <= pend_write;    // Write miss leaves the new line dirty
            end
        end
    end

    // Address and victim data of the pending transfer
    always_ff @(posedge clk) begin
        if (state == IDLE && stall) begin
            if (dirty[index]) begin
                mem_addr_q  <= victim_addr;
                mem_wdata_q <= line_out;
            end else begin
                mem_addr_q  <= req_line;
            end
        end else if (state == WRITE_BACK && mem_rsp.ready) begin
            mem_addr_q <= req_line;
        end
    end

    assign mem_req = '{read: mem_read_q, write: mem_write_q, addr: mem_addr_q, wdata: mem_wdata_q};

endmodule

/* src/cache_subsystem.sv */
// Cache subsystem top level with the instruction and data caches
`timescale 1ns/1ns

module cache_subsystem #(
    parameter int NUM_LINES = 8  // Power of two
) (
    input  logic                  clk,
    input  logic                  rst_n,

    // Instruction fetch side
    input  logic                  fetch_read,
    input  cache_pkg::word_addr_t fetch_addr,
    output cache_pkg::word_t      fetch_rdata,
    output logic                  fetch_stall,

    // Data access side
    input  cache_pkg::proc_req_t  data_req,
    output cache_pkg::word_t      data_rdata,
    output logic                  data_stall,

    // Instruction memory
    output logic                  imem_read,
    output cache_pkg::line_addr_t imem_addr,
    input  cache_pkg::mem_rsp_t   imem_rsp,

    // Data memory
    output cache_pkg::mem_req_t   dmem_req,
    input  cache_pkg::mem_rsp_t   dmem_rsp
);

    // ----------------------------------------
    // Independent instruction and data caches
    // ----------------------------------------
    icache #(
        .NUM_LINES (NUM_LINES)
    ) u_icache (
        .clk         (clk),
        .rst_n       (rst_n),
        .fetch_read  (fetch_read),
        .fetch_addr  (fetch_addr),
        .fetch_rdata (fetch_rdata),
        .fetch_stall (fetch_stall),
        .mem_read    (imem_read),
        .mem_addr    (imem_addr),
        .mem_rsp     (imem_rsp)
    );

    dcache #(
        .NUM_LINES (NUM_LINES)
    ) u_dcache (
        .clk     (clk),
        .rst_n   (rst_n),
        .req     (data_req),
        .rdata   (data_rdata),
        .stall   (data_stall),
        .mem_req (dmem_req),
        .mem_rsp (dmem_rsp)
    );

endmodule

/* tests/slow_mem.sv */
// Line-wide memory model with fixed latency, one-cycle ready pulse and a preload port
`timescale 1ns/1ns

module slow_mem #(
    parameter int LATENCY = 3,
    parameter int DEPTH   = 64   // Depth in lines with wrapping addresses
) (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  read,
    input  logic                  write,
    input  cache_pkg::line_addr_t addr,
    input  cache_pkg::line_t      wdata,
    output cache_pkg::mem_rsp_t   rsp,
    input  logic                  load_en,
    input  cache_pkg::line_addr_t load_addr,
    input  cache_pkg::line_t      load_data
);
    import cache_pkg::*;

    localparam int AW = $clog2(DEPTH);

    line_t         mem [DEPTH];
    int            count;
    logic [AW-1:0] idx;

    assign idx = addr[AW-1:0];

    // Request level ignored in the ready cycle while the cache drops it
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            count <= 0;
            rsp   <= '0;
        end else begin
            rsp.ready <= 1'b0;
            if ((read || write) && !rsp.ready) begin
                if (count == LATENCY - 1) begin
                    count     <= 0;
                    rsp.ready <= 1'b1;
                    if (write) begin
                        mem[idx] <= wdata;
                    end else begin
                        rsp.rdata <= mem[idx];  // Valid with ready
                    end
                end else begin
                    count <= count + 1;
                end
            end
        end
        if (load_en) begin
            mem[load_addr[AW-1:0]] <= load_data;  // Preload before traffic
        end
    end

endmodule

/* tests/tb_cache_subsystem.sv */
// Cache subsystem testbench with memory models, reference memories and directed tests
`timescale 1ns/1ns

module tb_cache_subsystem;
    import cache_pkg::*;

    localparam int NUM_LINES    = 8;
    localparam int IMEM_LATENCY = 3;
    localparam int DMEM_LATENCY = 5;
    localparam int MEM_LINES    = 64;
    localparam int MEM_AW       = 8;    // Word address bits the models decode
    localparam int MEM_WORDS    = MEM_LINES * WORDS_PER_LINE;
    localparam int TIMEOUT      = 100;  // Cycles per wait

    logic       clk = 1'b0;
    logic       rst_n;
    logic       fetch_read;
    word_addr_t fetch_addr;
    word_t      fetch_rdata;
    logic       fetch_stall;
    proc_req_t  data_req;
    word_t      data_rdata;
    logic       data_stall;
    logic       imem_read;
    line_addr_t imem_addr;
    mem_rsp_t   imem_rsp;
    mem_req_t   dmem_req;
    mem_rsp_t   dmem_rsp;

    // Preload port shared by both models
    logic       load_en;
    line_addr_t load_addr;
    line_t      imem_load_data;
    line_t      dmem_load_data;

    // Reference contents and traffic seen at the memory ports
    word_t      ref_imem [MEM_WORDS];
    word_t      ref_dmem [MEM_WORDS];
    int         imem_fills  = 0;
    int         dmem_reads  = 0;
    int         dmem_writes = 0;
    line_addr_t wb_addr;
    line_t      wb_line;

    always #2 clk = ~clk;

    cache_subsystem #(
        .NUM_LINES (NUM_LINES)
    ) DUT (
        .clk         (clk),
        .rst_n       (rst_n),
        .fetch_read  (fetch_read),
        .fetch_addr  (fetch_addr),
        .fetch_rdata (fetch_rdata),
        .fetch_stall (fetch_stall),
        .data_req    (data_req),
        .data_rdata  (data_rdata),
        .data_stall  (data_stall),
        .imem_read   (imem_read),
        .imem_addr   (imem_addr),
        .imem_rsp    (imem_rsp),
        .dmem_req    (dmem_req),
        .dmem_rsp    (dmem_rsp)
    );

    slow_mem #(
        .LATENCY (IMEM_LATENCY),
        .DEPTH   (MEM_LINES)
    ) u_imem (
        .clk       (clk),
        .rst_n     (rst_n),
        .read      (imem_read),
        .write     (1'b0),
        .addr      (imem_addr),
        .wdata     ('0),
        .rsp       (imem_rsp),
        .load_en   (load_en),
        .load_addr (load_addr),
        .load_data (imem_load_data)
    );

    slow_mem #(
        .LATENCY (DMEM_LATENCY),
        .DEPTH   (MEM_LINES)
    ) u_dmem (
        .clk       (clk),
        .rst_n     (rst_n),
        .read      (dmem_req.read),
        .write     (dmem_req.write),
        .addr      (dmem_req.addr),
        .wdata     (dmem_req.wdata),
        .rsp       (dmem_rsp),
        .load_en   (load_en),
        .load_addr (load_addr),
        .load_data (dmem_load_data)
    );

    // Transfer monitor
    always @(posedge clk) begin
        if (imem_rsp.ready) imem_fills <= imem_fills + 1;
        if (dmem_rsp.ready && dmem_req.read) dmem_reads <= dmem_reads + 1;
        if (dmem_rsp.ready && dmem_req.write) begin
            dmem_writes <= dmem_writes + 1;
            wb_addr     <= dmem_req.addr;   // Victim line as it leaves
            wb_line     <= dmem_req.wdata;
        end
    end

    // ----------------------------------------
    // Helpers
    // ----------------------------------------
    function automatic word_addr_t word_at(input int tag, input int index, input int offset);
        return word_addr_t'((tag * NUM_LINES + index) * WORDS_PER_LINE + offset);
    endfunction

    // Line address of a tag and index pair
    function automatic line_addr_t line_at(input int tag, input int index);
        return line_addr_t'(tag * NUM_LINES + index);
    endfunction

    function automatic logic [MEM_AW-1:0] ref_slot(input word_addr_t a);
        return a[MEM_AW-1:0];
    endfunction

    task automatic expect_word(input string what, input word_t got, input word_t exp);
        assert (got === exp) else begin
            $display("MISMATCH at %0t ns: %s is %h, expected %h", $time, what, got, exp);
            $display("Some tests failed");
            $fatal(1);
        end
    endtask

    task automatic expect_bit(input string what, input logic got, input logic exp);
        assert (got === exp) else begin
            $display("MISMATCH at %0t ns: %s is %b, expected %b", $time, what, got, exp);
            $display("Some tests failed");
            $fatal(1);
        end
    endtask

    task automatic report_timeout(input string what);
        $display("Timeout at %0t ns: %s still stalled after %0d cycles", $time, what, TIMEOUT);
        $display("Some tests failed");
        $fatal(1);
    endtask

    // Fills both models with random lines and mirrors them in the reference arrays
    task automatic load_memories();
        line_t iline;
        line_t dline;
        for (int l = 0; l < MEM_LINES; l++) begin
            for (int w = 0; w < WORDS_PER_LINE; w++) begin
                ref_imem[l * WORDS_PER_LINE + w] = $urandom;
                ref_dmem[l * WORDS_PER_LINE + w] = $urandom;
                iline[w*WORD_BITS +: WORD_BITS] = ref_imem[l * WORDS_PER_LINE + w];
                dline[w*WORD_BITS +: WORD_BITS] = ref_dmem[l * WORDS_PER_LINE + w];
            end
            @(negedge clk);
            load_en        = 1'b1;
            load_addr      = line_addr_t'(l);
            imem_load_data = iline;
            dmem_load_data = dline;
        end
        @(negedge clk);
        load_en = 1'b0;
    endtask

    // Counts stalled cycles from the current sample point
    task automatic wait_fetch(output int stalls);
        stalls = 0;
        while (fetch_stall) begin
            stalls++;
            if (stalls > TIMEOUT) report_timeout("instruction fetch");
            @(negedge clk);
            #1;
        end
    endtask

    task automatic wait_data(output int stalls);
        stalls = 0;
        while (data_stall) begin
            stalls++;
            if (stalls > TIMEOUT) report_timeout("data access");
            @(negedge clk);
            #1;
        end
    endtask

    task automatic fetch_word(input word_addr_t a, output word_t data, output int stalls);
        @(negedge clk);
        fetch_read = 1'b1;
        fetch_addr = a;
        #1;
        wait_fetch(stalls);
        data = fetch_rdata;
        @(negedge clk);
        fetch_read = 1'b0;
    endtask

    task automatic data_access(input logic is_write, input word_addr_t a, input word_t wdata,
                               output word_t data, output int stalls);
        @(negedge clk);
        data_req = '{read: ~is_write, write: is_write, addr: a, wdata: wdata};
        #1;
        wait_data(stalls);
        data = data_rdata;
        @(negedge clk);
        data_req = '0;
    endtask

    // A negative stall count means any count is fine
    task automatic fetch_and_check(input word_addr_t a, input int exp_stalls);
        word_t data;
        int    stalls;
        fetch_word(a, data, stalls);
        expect_word("fetch_rdata", data, ref_imem[ref_slot(a)]);
        if (exp_stalls >= 0) expect_word("fetch stall cycles", stalls, exp_stalls);
    endtask

    task automatic read_and_check(input word_addr_t a, input int exp_stalls);
        word_t data;
        int    stalls;
        data_access(1'b0, a, '0, data, stalls);
        expect_word("data_rdata", data, ref_dmem[ref_slot(a)]);
        if (exp_stalls >= 0) expect_word("data read stall cycles", stalls, exp_stalls);
    endtask

    task automatic write_word(input word_addr_t a, input word_t value, input int exp_stalls);
        word_t data;
        int    stalls;
        data_access(1'b1, a, value, data, stalls);
        ref_dmem[ref_slot(a)] = value;
        if (exp_stalls >= 0) expect_word("data write stall cycles", stalls, exp_stalls);
    endtask

    // ----------------------------------------
    // Directed tests
    // ----------------------------------------
    task automatic test_reset_and_first_fetch();
        word_addr_t a;
        int         stalls;
        a = word_at(2, 0, 0);
        @(negedge clk);
        #1;
        expect_bit("fetch_stall when idle", fetch_stall, 1'b0);
        expect_bit("data_stall when idle", data_stall, 1'b0);
        expect_bit("imem_read when idle", imem_read, 1'b0);
        expect_bit("dmem read when idle", dmem_req.read, 1'b0);
        expect_bit("dmem write when idle", dmem_req.write, 1'b0);
        @(negedge clk);
        fetch_read = 1'b1;
        fetch_addr = a;
        #1;
        expect_bit("fetch_stall on first fetch", fetch_stall, 1'b1);
        @(negedge clk);
        #1;
        expect_bit("imem_read after miss", imem_read, 1'b1);
        expect_word("imem_addr", word_t'(imem_addr), word_t'(line_at(2, 0)));
        wait_fetch(stalls);
        expect_word("first fetch rdata", fetch_rdata, ref_imem[ref_slot(a)]);
        expect_word("first fetch stall cycles", stalls + 1, IMEM_LATENCY + 2);
        @(negedge clk);
        fetch_read = 1'b0;
    endtask

    task automatic test_ifill_then_hits();
        int fills;
        fetch_and_check(word_at(1, 1, 2), IMEM_LATENCY + 2);
        fills = imem_fills;
        for (int w = 0; w < WORDS_PER_LINE; w++) begin
            if (w != 2) fetch_and_check(word_at(1, 1, w), 0);
        end
        expect_word("instruction fills during hits", imem_fills, fills);
        expect_bit("imem_read after hits", imem_read, 1'b0);
    endtask

    task automatic test_write_hit();
        word_addr_t a;
        int         traffic;
        a = word_at(0, 2, 1);
        read_and_check(a, DMEM_LATENCY + 2);
        traffic = dmem_reads + dmem_writes;
        write_word(a, $urandom, 0);
        read_and_check(a, 0);
        expect_word("data transfers around write hit", dmem_reads + dmem_writes, traffic);
        expect_bit("dmem read after write hit", dmem_req.read, 1'b0);
        expect_bit("dmem write after write hit", dmem_req.write, 1'b0);
    endtask

    task automatic test_dirty_eviction();
        word_addr_t b;
        word_t      v;
        int         writes;
        b = word_at(1, 5, 3);
        v = $urandom;
        write_word(b, v, DMEM_LATENCY + 2);             // Write miss on a clean line
        writes = dmem_writes;
        read_and_check(word_at(2, 5, 0), 2 * DMEM_LATENCY + 3);
        expect_word("write-back count", dmem_writes, writes + 1);
        expect_word("write-back address", word_t'(wb_addr), word_t'(line_at(1, 5)));
        expect_word("written word in victim line", wb_line[3*WORD_BITS +: WORD_BITS], v);
        for (int w = 0; w < WORDS_PER_LINE; w++) begin
            expect_word("victim line word", wb_line[w*WORD_BITS +: WORD_BITS],
                        ref_dmem[ref_slot(word_at(1, 5, w))]);
        end
        read_and_check(b, DMEM_LATENCY + 2);            // Comes back from memory
    endtask

    task automatic test_random_traffic();
        int tag;
        int index;
        int offset;
        for (int n = 0; n < 200; n++) begin
            tag    = $urandom_range(3, 0);
            index  = $urandom_range(1, 0);
            offset = $urandom_range(3, 0);
            if ($urandom_range(1, 0) == 1) begin
                write_word(word_at(tag, index, offset), $urandom, -1);
            end else begin
                read_and_check(word_at(tag, index, offset), -1);
            end
        end
    endtask

    task automatic test_concurrent_misses();
        word_addr_t fa;
        word_addr_t da;
        word_t      fdata;
        word_t      ddata;
        int         istalls;
        int         dstalls;
        time        idone;
        time        ddone;
        fa = word_at(3, 6, 1);
        da = word_at(3, 7, 2);
        fork
            begin
                fetch_word(fa, fdata, istalls);
                idone = $time;
            end
            begin
                data_access(1'b0, da, '0, ddata, dstalls);
                ddone = $time;
            end
        join
        expect_word("concurrent fetch rdata", fdata, ref_imem[ref_slot(fa)]);
        expect_word("concurrent data rdata", ddata, ref_dmem[ref_slot(da)]);
        expect_word("concurrent fetch stall cycles", istalls, IMEM_LATENCY + 2);
        expect_word("concurrent data stall cycles", dstalls, DMEM_LATENCY + 2);
        expect_bit("fetch done before data read", idone < ddone, 1'b1);
    endtask

    initial begin
        void'($urandom(32'h330ed6d6));
        rst_n          = 1'b0;
        fetch_read     = 1'b0;
        fetch_addr     = '0;
        data_req       = '0;
        load_en        = 1'b0;
        load_addr      = '0;
        imem_load_data = '0;
        dmem_load_data = '0;
        repeat (3) @(negedge clk);
        rst_n = 1'b1;
        load_memories();
        test_reset_and_first_fetch();
        test_ifill_then_hits();
        test_write_hit();
        test_dirty_eviction();
        test_random_traffic();
        test_concurrent_misses();
        $display("All tests passed");
        $finish;
    end

endmodule

/* verilog.f */
src/cache_pkg.sv
src/cache_line_store.sv
src/icache.sv
src/dcache.sv
src/cache_subsystem.sv
tests/slow_mem.sv
tests/tb_cache_subsystem.sv

/* run.sh */
#!/bin/sh
# Compile and run the cache subsystem testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert --timescale 1ns/1ns \
    --top-module tb_cache_subsystem -f verilog.f -o tb_cache_subsystem > sim.log 2>&1 &&
    ./obj_dir/tb_cache_subsystem >> sim.log 2>&1
cat sim.log
grep -q "All tests passed" sim.log && echo "PASS" || { echo "FAIL"; exit 1; }
